// File: bench/fetch_trace.txt
# M addr word expected_instr illegal bus_err   (hex, hex, hex, dec, dec)
# E cycle kind value (S/H stall cycles, J/B/M target, X trap, I irq id, F wb pc); D done pc
M 00000100 00500093 00500093 0 0
M 00000104 00004515 00500513 0 0
M 00000108 000085aa 00a005b3 0 0
M 0000010c 00000000 00000000 1 0
M 00000110 00000013 00000013 0 1
M 00000114 00000405 00140413 0 0
M 00000200 00000297 00000297 0 0
M 00000204 0000962e 00b60633 0 0
M 00002000 30200073 30200073 0 0
M 000003f4 00004080 0004a403 0 0
E 20 S 4
E 30 J 00000200
E 45 H 3
E 55 X 0
E 70 I 3
E 85 M 00000300
E 100 B 00000108
E 115 F 000003f0
D 000003f8

// File: vlog.f
source/fetch_pkg.sv
source/fetch_pc_select.sv
source/fetch_prefetch.sv
source/fetch_rvc_expand.sv
source/fetch_stage.sv
bench/fetch_sva.sv
bench/fetch_checker.sv
bench/fetch_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the fetch stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module fetch_tb -f vlog.f -o fetch_sim

./obj_dir/fetch_sim | tee sim.log

if grep -q "^STATUS: PASS$" sim.log; then
  exit 0
fi
exit 1

// File: bench/fetch_tb.sv
/*
  Testbench for fetch_stage: reads the trace, models the instruction
  memory with random grant and response delays, and plays redirect and
  stall events. Checking is done in fetch_checker.
*/

`timescale 1ns/1ps

module fetch_tb;
  import fetch_pkg::*;

  localparam logic [31:0] BOOT_ADDR = 32'h0000_0100;
  localparam logic [23:0] MTVEC     = 24'h00_0020;

  logic clk = 1'b0;
  logic rst_n;
  logic req_i, kill_if_i, pc_set_i;
  pc_src_e pc_src_i;
  trap_vec_e trap_vec_i;
  logic [IRQ_ID_W-1:0] irq_id_i;
  logic [31:0] jump_target_i, branch_target_i, mepc_i, dpc_i, wb_pc_i;
  logic clear_instr_valid_i, halt_if_i, id_ready_i;
  logic instr_req_o, instr_gnt_i, instr_rvalid_i, instr_err_i;
  logic [31:0] instr_addr_o, instr_rdata_i;
  logic instr_valid_o, is_compressed_o, illegal_c_o, bus_err_o, mtvec_init_o, busy_o;
  logic [31:0] instr_o, pc_id_o, pc_if_o;
  logic [15:0] compressed_instr_o;

  logic [31:0] mem_word [logic [31:0]];
  logic        mem_err  [logic [31:0]];
  int          ev_cycle [$];
  byte         ev_kind  [$];
  logic [31:0] ev_val   [$];
  logic [31:0] done_addr;
  logic [31:0] exp_target;
  logic        checker_done;
  logic [31:0] rsp_q [$];
  int line_cnt = 0;
  int cycle = 0;
  int ev_idx = 0;
  int stall_left = 0;
  int halt_left = 0;
  int rsp_wait = 0;
  int bench_errors = 0;
  bit trace_ok;

  always #50 clk = ~clk;

  fetch_stage dut_i (
    .clk (clk), .rst_n (rst_n), .req_i (req_i), .kill_if_i (kill_if_i),
    .pc_set_i (pc_set_i), .pc_src_i (pc_src_i), .trap_vec_i (trap_vec_i),
    .irq_id_i (irq_id_i), .boot_addr_i (BOOT_ADDR), .mtvec_addr_i (MTVEC),
    .dm_halt_addr_i (32'h0000_0800), .dm_exception_addr_i (32'h0000_0808),
    .jump_target_i (jump_target_i), .branch_target_i (branch_target_i),
    .mepc_i (mepc_i), .dpc_i (dpc_i), .wb_pc_i (wb_pc_i),
    .clear_instr_valid_i (clear_instr_valid_i), .halt_if_i (halt_if_i),
    .id_ready_i (id_ready_i), .instr_req_o (instr_req_o), .instr_addr_o (instr_addr_o),
    .instr_gnt_i (instr_gnt_i), .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i (instr_rdata_i), .instr_err_i (instr_err_i),
    .instr_valid_o (instr_valid_o), .instr_o (instr_o), .pc_id_o (pc_id_o),
    .is_compressed_o (is_compressed_o), .illegal_c_o (illegal_c_o),
    .bus_err_o (bus_err_o), .compressed_instr_o (compressed_instr_o),
    .pc_if_o (pc_if_o), .mtvec_init_o (mtvec_init_o), .busy_o (busy_o)
  );

  fetch_checker checker_i (
    .clk (clk), .rst_n (rst_n), .instr_valid_i (instr_valid_o), .instr_i (instr_o),
    .pc_id_i (pc_id_o), .pc_if_i (pc_if_o), .is_compressed_i (is_compressed_o),
    .illegal_c_i (illegal_c_o), .bus_err_i (bus_err_o),
    .compressed_instr_i (compressed_instr_o),
    .mtvec_init_i (mtvec_init_o), .id_ready_i (id_ready_i), .halt_if_i (halt_if_i),
    .pc_set_i (pc_set_i), .target_i (exp_target), .done_addr_i (done_addr),
    .done_o (checker_done)
  );

  //////////////////////////////////////////////////////////////////////
  // trace reading
  //////////////////////////////////////////////////////////////////////

  task automatic load_trace(output bit ok);
    int fd;
    string line, tag, ev;
    logic [31:0] addr, word, expv, val;
    int ill, err, cyc;
    fd = $fopen("bench/fetch_trace.txt", "r");
    ok = (fd != 0);
    while (ok && !$feof(fd))
    begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.getc(0) == "#")
        continue;
      void'($sscanf(line, "%s", tag));
      line_cnt++;
      if (tag == "M")
      begin
        void'($sscanf(line, "M %h %h %h %d %d", addr, word, expv, ill, err));
        mem_word[addr] = word;
        mem_err[addr]  = err[0];
        checker_i.add_word(addr, word, expv, ill[0], err[0]);
      end
      else if (tag == "E")
      begin
        void'($sscanf(line, "E %d %s %h", cyc, ev, val));
        ev_cycle.push_back(cyc);
        ev_kind.push_back(ev.getc(0));
        ev_val.push_back(val);
      end
      else if (tag == "D")
        void'($sscanf(line, "D %h", done_addr));
    end
    if (ok)
      $fclose(fd);
  endtask

  //////////////////////////////////////////////////////////////////////
  // boot, redirect and stall stimulus
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    logic [31:0] tgt;
    logic [31:0] v;
    bit redirect;
    bit ready;
    bit halted;
    redirect = 1'b0;
    tgt = '0;
    if (rst_n)
    begin
      cycle++;
      pc_set_i <= 1'b0;
      if (cycle == 1)
      begin
        req_i    <= 1'b1;
        pc_src_i <= PC_BOOT;
        redirect = 1'b1;
        tgt      = BOOT_ADDR;
      end
      if (ev_idx < ev_cycle.size() && ev_cycle[ev_idx] == cycle)
      begin
        v = ev_val[ev_idx];
        redirect = 1'b1;
        case (ev_kind[ev_idx])
          "S":
          begin
            stall_left = v;
            redirect   = 1'b0;
          end
          "H":
          begin
            halt_left = v;
            redirect  = 1'b0;
          end
          "J":
          begin
            pc_src_i      <= PC_JUMP;
            jump_target_i <= v;
            tgt           = v;
          end
          "B":
          begin
            pc_src_i        <= PC_BRANCH;
            branch_target_i <= v;
            tgt             = v;
          end
          "X":
          begin
            pc_src_i   <= PC_TRAP;
            trap_vec_i <= TRAP_EXC;
            tgt        = {MTVEC, 8'h00};
          end
          "I":
          begin
            // vectored entry is one word per interrupt line
            pc_src_i   <= PC_TRAP;
            trap_vec_i <= TRAP_IRQ;
            irq_id_i   <= v[IRQ_ID_W-1:0];
            tgt        = {MTVEC, 8'h00} + v * 4;
          end
          "M":
          begin
            pc_src_i <= PC_MRET;
            mepc_i   <= v;
            tgt      = v;
          end
          "F":
          begin
            pc_src_i <= PC_FENCEI;
            wb_pc_i  <= v;
            tgt      = v + 32'd4;
          end
          default: redirect = 1'b0;
        endcase
        ev_idx++;
      end
      if (redirect)
      begin
        pc_set_i   <= 1'b1;
        exp_target <= {tgt[31:2], 2'b00};
      end
      ready  = (stall_left == 0);
      halted = (halt_left > 0);
      if (stall_left > 0)
        stall_left--;
      if (halt_left > 0)
        halt_left--;
      id_ready_i          <= ready;
      halt_if_i           <= halted;
      // decode drops its word once taken, and on a redirect
      clear_instr_valid_i <= (ready && !halted) || redirect;
    end
  end

  // memory model with random grant and in-order responses after a random wait
  always @(posedge clk)
  begin
    logic [31:0] a;
    if (rst_n)
    begin
      if (instr_req_o && instr_gnt_i)
        rsp_q.push_back(instr_addr_o);
      instr_gnt_i <= ($urandom_range(2) != 0);
      if (rsp_q.size() > 0 && rsp_wait == 0)
      begin
        a = rsp_q.pop_front();
        instr_rvalid_i <= 1'b1;
        instr_rdata_i  <= mem_word.exists(a) ? mem_word[a] : NOP_INSTR;
        instr_err_i    <= mem_err.exists(a) ? mem_err[a] : 1'b0;
        rsp_wait = $urandom_range(2);
      end
      else
      begin
        instr_rvalid_i <= 1'b0;
        if (rsp_wait > 0)
          rsp_wait--;
      end
    end
  end

  initial
  begin
    void'($urandom(32'hd588_851c));
    rst_n = 1'b0;
    req_i = 1'b0;
    kill_if_i = 1'b0;
    pc_set_i = 1'b0;
    pc_src_i = PC_BOOT;
    trap_vec_i = TRAP_EXC;
    irq_id_i = '0;
    jump_target_i = '0;
    branch_target_i = '0;
    mepc_i = '0;
    dpc_i = '0;
    wb_pc_i = '0;
    clear_instr_valid_i = 1'b0;
    halt_if_i = 1'b0;
    id_ready_i = 1'b1;
    instr_gnt_i = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i = '0;
    instr_err_i = 1'b0;
    exp_target = '0;
    done_addr = '0;
    load_trace(trace_ok);
    if (!trace_ok)
    begin
      $display("could not open bench/fetch_trace.txt");
      bench_errors++;
    end
    else
    begin
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      // limit scales with the trace length
      while (!checker_done && cycle < line_cnt * 20)
        @(posedge clk);
      if (!checker_done)
      begin
        $display("timeout, the run did not finish within %0d cycles", line_cnt * 20);
        bench_errors++;
      end
      checker_i.final_check();
    end
    $display("errors: checker %0d, bench %0d", checker_i.err_cnt, bench_errors);
    if (checker_i.err_cnt == 0 && bench_errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: bench/fetch_checker.sv
/*
  Scoreboard for the IF/ID outputs. The bench loads the expected image
  through add_word; every word taken by decode is compared here.
*/

`timescale 1ns/1ps

module fetch_checker (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        instr_valid_i,
  input  logic [31:0] instr_i,
  input  logic [31:0] pc_id_i,
  input  logic [31:0] pc_if_i,
  input  logic        is_compressed_i,
  input  logic        illegal_c_i,
  input  logic        bus_err_i,
  input  logic [15:0] compressed_instr_i,
  input  logic        mtvec_init_i,
  input  logic        id_ready_i,
  input  logic        halt_if_i,
  input  logic        pc_set_i,
  input  logic [31:0] target_i,
  input  logic [31:0] done_addr_i,
  output logic        done_o
);
  import fetch_pkg::*;

  int          err_cnt = 0;
  int          boot_pulses = 0;
  logic [31:0] exp_pc;
  logic        slot_q;
  logic [31:0] pc_if_q;
  logic [31:0] img_raw [logic [31:0]];
  logic [31:0] img_exp [logic [31:0]];
  logic        img_ill [logic [31:0]];
  logic        img_err [logic [31:0]];

  task automatic add_word(input logic [31:0] addr, input logic [31:0] raw,
                          input logic [31:0] expv, input logic ill, input logic err);
    img_raw[addr] = raw;
    img_exp[addr] = expv;
    img_ill[addr] = ill;
    img_err[addr] = err;
  endtask

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // compare one word handed to decode against the image at the expected pc
  task automatic check_word();
    logic [31:0] raw;
    logic [31:0] expv;
    logic        ill;
    logic        err;
    raw  = NOP_INSTR;
    expv = NOP_INSTR;
    ill  = 1'b0;
    err  = 1'b0;
    if (img_raw.exists(exp_pc))
    begin
      raw  = img_raw[exp_pc];
      expv = img_exp[exp_pc];
      ill  = img_ill[exp_pc];
      err  = img_err[exp_pc];
    end
    compare("pc_id_o", pc_id_i, exp_pc);
    compare("instr_o", instr_i, expv);
    compare("is_compressed_o", {31'd0, is_compressed_i}, {31'd0, raw[1:0] != 2'b11});
    compare("illegal_c_o", {31'd0, illegal_c_i}, {31'd0, ill});
    compare("bus_err_o", {31'd0, bus_err_i}, {31'd0, err});
    compare("compressed_instr_o", {16'd0, compressed_instr_i}, {16'd0, raw[15:0]});
    if (pc_id_i == done_addr_i)
      done_o <= 1'b1;
  endtask

  task automatic final_check();
    if (boot_pulses != 1)
    begin
      err_cnt++;
      $display("[FAIL] %0t: mtvec_init_o pulsed %0d times, expected once", $time,
               boot_pulses);
    end
  endtask

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      exp_pc  <= '0;
      done_o  <= 1'b0;
      slot_q  <= 1'b0;
      pc_if_q <= '0;
    end
    else
    begin
      if (mtvec_init_i)
        boot_pulses++;
      if (instr_valid_i && id_ready_i && !halt_if_i)
        check_word();
      // a word loaded at the last edge was the FIFO head seen on pc_if_o
      if (slot_q && instr_valid_i)
        compare("pc_if_o", pc_if_q, exp_pc);
      // IF/ID open for a new word at this edge
      slot_q  <= id_ready_i && !halt_if_i && !pc_set_i;
      pc_if_q <= pc_if_i;
      // older path ends at the redirect edge
      if (pc_set_i)
        exp_pc <= target_i;
      else if (instr_valid_i && id_ready_i && !halt_if_i)
        exp_pc <= exp_pc + 32'd4;
    end
  end

endmodule

// File: bench/fetch_sva.sv
/*
  Concurrent assertions on the fetch stage, bound into fetch_stage.
  Covers the memory handshake and IF/ID hold during decode stalls.
*/

`timescale 1ns/1ps

module fetch_sva (
  input logic        clk,
  input logic        rst_n,
  input logic        kill_if_i,
  input logic        pc_set_i,
  input logic        id_ready_i,
  input logic        halt_if_i,
  input logic        instr_req_o,
  input logic [31:0] instr_addr_o,
  input logic        instr_gnt_i,
  input logic        instr_rvalid_i,
  input logic        busy_o,
  input logic        instr_valid_o,
  input logic [31:0] instr_o,
  input logic [31:0] pc_id_o,
  input logic        is_compressed_o,
  input logic        illegal_c_o,
  input logic        bus_err_o,
  input logic [15:0] compressed_instr_o
);

  // address phase holds until granted unless a redirect or kill withdraws it
  req_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_req_o && !instr_gnt_i) |=>
      (pc_set_i || kill_if_i || (instr_req_o && $stable(instr_addr_o))))
    else $error("request dropped or address changed before grant");

  // a response needs a transaction in flight
  rsp_owed_a: assert property (@(posedge clk) disable iff (!rst_n)
    instr_rvalid_i |-> busy_o)
    else $error("rvalid with nothing outstanding");

  // IF/ID frozen while decode is not taking words
  ifid_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    (!id_ready_i || halt_if_i) |=>
      ($stable(instr_valid_o) && $stable(instr_o) && $stable(pc_id_o) &&
       $stable(is_compressed_o) && $stable(illegal_c_o) && $stable(bus_err_o) &&
       $stable(compressed_instr_o)))
    else $error("IF/ID changed during a stall");

endmodule

bind fetch_stage fetch_sva sva_i (.*);

// File: source/fetch_stage.sv
/*
  Instruction fetch stage top: PC selection, prefetch, compressed
  expansion and the IF/ID register facing decode.
  The register holds while decode stalls and loads one word per handshake.
*/

`timescale 1ns/1ps

module fetch_stage (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          req_i,
  input  logic                          kill_if_i,
  input  logic                          pc_set_i,
  input  fetch_pkg::pc_src_e            pc_src_i,
  input  fetch_pkg::trap_vec_e          trap_vec_i,
  input  logic [fetch_pkg::IRQ_ID_W-1:0] irq_id_i,
  input  logic [fetch_pkg::XLEN-1:0]    boot_addr_i,
  input  logic [23:0]                   mtvec_addr_i,
  input  logic [fetch_pkg::XLEN-1:0]    dm_halt_addr_i,
  input  logic [fetch_pkg::XLEN-1:0]    dm_exception_addr_i,
  input  logic [fetch_pkg::XLEN-1:0]    jump_target_i,
  input  logic [fetch_pkg::XLEN-1:0]    branch_target_i,
  input  logic [fetch_pkg::XLEN-1:0]    mepc_i,
  input  logic [fetch_pkg::XLEN-1:0]    dpc_i,
  input  logic [fetch_pkg::XLEN-1:0]    wb_pc_i,
  input  logic                          clear_instr_valid_i,
  input  logic                          halt_if_i,
  input  logic                          id_ready_i,
  output logic                          instr_req_o,
  output logic [fetch_pkg::XLEN-1:0]    instr_addr_o,
  input  logic                          instr_gnt_i,
  input  logic                          instr_rvalid_i,
  input  logic [fetch_pkg::XLEN-1:0]    instr_rdata_i,
  input  logic                          instr_err_i,
  output logic                          instr_valid_o,
  output logic [fetch_pkg::XLEN-1:0]    instr_o,
  output logic [fetch_pkg::XLEN-1:0]    pc_id_o,
  output logic                          is_compressed_o,
  output logic                          illegal_c_o,
  output logic                          bus_err_o,
  output logic [15:0]                   compressed_instr_o,
  output logic [fetch_pkg::XLEN-1:0]    pc_if_o,
  output logic                          mtvec_init_o,
  output logic                          busy_o
);
  import fetch_pkg::*;

  logic [XLEN-1:0] branch_addr;
  logic            fetch_valid;
  logic [XLEN-1:0] fetch_data;
  logic            fetch_err;
  logic [XLEN-1:0] fetch_pc;
  logic [XLEN-1:0] exp_instr;
  logic            exp_compressed;
  logic            exp_illegal;
  logic            if_ready;
  logic            if_valid;

  fetch_pc_select pc_select_i (
    .pc_src_i            (pc_src_i),
    .trap_vec_i          (trap_vec_i),
    .irq_id_i            (irq_id_i),
    .boot_addr_i         (boot_addr_i),
    .mtvec_addr_i        (mtvec_addr_i),
    .dm_halt_addr_i      (dm_halt_addr_i),
    .dm_exception_addr_i (dm_exception_addr_i),
    .jump_target_i       (jump_target_i),
    .branch_target_i     (branch_target_i),
    .mepc_i              (mepc_i),
    .dpc_i               (dpc_i),
    .wb_pc_i             (wb_pc_i),
    .target_o            (branch_addr)
  );

  fetch_prefetch prefetch_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .enable_i       (req_i),
    .kill_i         (kill_if_i),
    .branch_req_i   (pc_set_i),
    .branch_addr_i  (branch_addr),
    .ready_i        (if_ready),
    .valid_o        (fetch_valid),
    .instr_o        (fetch_data),
    .err_o          (fetch_err),
    .pc_o           (fetch_pc),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .busy_o         (busy_o)
  );

  fetch_rvc_expand rvc_expand_i (
    .instr_i         (fetch_data),
    .instr_o         (exp_instr),
    .is_compressed_o (exp_compressed),
    .illegal_o       (exp_illegal)
  );

  //////////////////////////////////////////////////////////////////////
  // handshake with decode
  //////////////////////////////////////////////////////////////////////

  assign if_ready = id_ready_i & ~halt_if_i;
  // a redirect or kill in this cycle makes the head word stale
  assign if_valid = if_ready & fetch_valid & ~pc_set_i & ~kill_if_i;

  // CSR file initialises mtvec on the boot redirect
  assign mtvec_init_o = pc_set_i & (pc_src_i == PC_BOOT);
  assign pc_if_o      = fetch_pc;

  // IF/ID register, frozen unless a word is handed over
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      instr_valid_o      <= 1'b0;
      instr_o            <= NOP_INSTR;
      pc_id_o            <= '0;
      is_compressed_o    <= 1'b0;
      illegal_c_o        <= 1'b0;
      bus_err_o          <= 1'b0;
      compressed_instr_o <= '0;
    end
    else if (if_valid)
    begin
      instr_valid_o      <= 1'b1;
      instr_o            <= exp_instr;
      pc_id_o            <= fetch_pc;
      is_compressed_o    <= exp_compressed;
      illegal_c_o        <= exp_illegal;
      bus_err_o          <= fetch_err;
      compressed_instr_o <= fetch_data[15:0];
    end
    else if (clear_instr_valid_i)
      instr_valid_o <= 1'b0;
  end

endmodule

// File: source/fetch_rvc_expand.sv
/*
  Compressed instruction expander for the FIFO head word.
  Known 16-bit forms are rebuilt as their 32-bit equivalents, other
  compressed forms are flagged illegal and full words pass through.
*/

`timescale 1ns/1ps

module fetch_rvc_expand (
  input  logic [fetch_pkg::XLEN-1:0] instr_i,
  output logic [fetch_pkg::XLEN-1:0] instr_o,
  output logic                       is_compressed_o,
  output logic                       illegal_o
);
  import fetch_pkg::*;

  rvc_op_e op;

  // quadrant and funct3 select the form
  always_comb
  begin
    op = C_ILLEGAL;
    case (instr_i[1:0])
      2'b00:
      begin
        if (instr_i[15:13] == 3'b010)
          op = C_LW;
        else if (instr_i[15:13] == 3'b110)
          op = C_SW;
      end
      2'b01:
      begin
        if (instr_i[15:13] == 3'b000)
          op = C_ADDI;
        else if (instr_i[15:13] == 3'b010)
          op = C_LI;
        else if (instr_i[15:13] == 3'b101)
          op = C_J;
      end
      2'b10:
      begin
        // rs2 of zero means jr/jalr/ebreak, not handled here
        if (instr_i[15:13] == 3'b100 && instr_i[6:2] != 5'd0)
          op = instr_i[12] ? C_ADD : C_MV;
      end
      default: op = C_ILLEGAL;
    endcase
  end

  always_comb
  begin
    is_compressed_o = (instr_i[1:0] != 2'b11);
    illegal_o       = 1'b0;
    instr_o         = instr_i;
    if (is_compressed_o)
    begin
      case (op)
        // lw rd', uimm(rs1')
        C_LW:   instr_o = {5'd0, instr_i[5], instr_i[12:10], instr_i[6], 2'b00,
                           2'b01, instr_i[9:7], 3'b010, 2'b01, instr_i[4:2], 7'b0000011};
        // sw rs2', uimm(rs1')
        C_SW:   instr_o = {5'd0, instr_i[5], instr_i[12], 2'b01, instr_i[4:2],
                           2'b01, instr_i[9:7], 3'b010, instr_i[11:10], instr_i[6],
                           2'b00, 7'b0100011};
        // addi rd, rd, imm
        C_ADDI: instr_o = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2], instr_i[11:7],
                           3'b000, instr_i[11:7], 7'b0010011};
        // addi rd, x0, imm
        C_LI:   instr_o = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2], 5'd0,
                           3'b000, instr_i[11:7], 7'b0010011};
        // jal x0, offset with the scrambled immediate put back in order
        C_J:    instr_o = {instr_i[12], instr_i[8], instr_i[10:9], instr_i[6], instr_i[7],
                           instr_i[2], instr_i[11], instr_i[5:3], instr_i[12],
                           {8{instr_i[12]}}, 5'd0, 7'b1101111};
        C_MV:   instr_o = {7'd0, instr_i[6:2], 5'd0, 3'b000, instr_i[11:7], 7'b0110011};
        C_ADD:  instr_o = {7'd0, instr_i[6:2], instr_i[11:7], 3'b000, instr_i[11:7],
                           7'b0110011};
        default:
        begin
          // raw halfword goes on to decode for the trap
          instr_o   = {16'd0, instr_i[15:0]};
          illegal_o = 1'b1;
        end
      endcase
    end
  end

endmodule

// File: source/fetch_prefetch.sv
/*
  Prefetch unit: issues word fetches on the request/grant/rvalid port,
  drops responses that belong to a flushed path, and buffers the rest
  in a small FIFO read by the fetch stage.
*/

`timescale 1ns/1ps

module fetch_prefetch (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          enable_i,
  input  logic                          kill_i,
  input  logic                          branch_req_i,
  input  logic [fetch_pkg::XLEN-1:0]    branch_addr_i,
  input  logic                          ready_i,
  output logic                          valid_o,
  output logic [fetch_pkg::XLEN-1:0]    instr_o,
  output logic                          err_o,
  output logic [fetch_pkg::XLEN-1:0]    pc_o,
  output logic                          instr_req_o,
  output logic [fetch_pkg::XLEN-1:0]    instr_addr_o,
  input  logic                          instr_gnt_i,
  input  logic                          instr_rvalid_i,
  input  logic [fetch_pkg::XLEN-1:0]    instr_rdata_i,
  input  logic                          instr_err_i,
  output logic                          busy_o
);
  import fetch_pkg::*;

  logic [XLEN-1:0]                       fetch_addr_q;
  logic [XLEN-1:0]                       rsp_pc_q;
  logic                                  active_q;
  logic [$clog2(FETCH_FIFO_DEPTH):0]     out_cnt_q;
  logic [$clog2(FETCH_FIFO_DEPTH):0]     out_cnt_n;
  logic [$clog2(FETCH_FIFO_DEPTH):0]     discard_cnt_q;
  logic [$clog2(FETCH_FIFO_DEPTH):0]     fifo_cnt_q;
  logic [$clog2(FETCH_FIFO_DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(FETCH_FIFO_DEPTH)-1:0]   rd_ptr_q;
  logic [XLEN-1:0]                       data_q [FETCH_FIFO_DEPTH];
  logic                                  err_q  [FETCH_FIFO_DEPTH];
  logic [XLEN-1:0]                       pc_q   [FETCH_FIFO_DEPTH];
  logic                                  flush;
  logic                                  gnt_hs;
  logic                                  rsp_drop;
  logic                                  push;
  logic                                  pop;

  assign flush    = branch_req_i | kill_i;
  assign gnt_hs   = instr_req_o & instr_gnt_i;
  // responses still owed to a flushed path
  assign rsp_drop = instr_rvalid_i & (discard_cnt_q != '0);
  assign push     = instr_rvalid_i & ~rsp_drop & ~flush;
  assign pop      = ready_i & valid_o & ~flush;

  // in flight plus buffered never exceeds the FIFO, so rvalid always fits
  assign instr_req_o  = enable_i & active_q & ~flush &
                        ((out_cnt_q + fifo_cnt_q) < FETCH_FIFO_DEPTH);
  assign instr_addr_o = fetch_addr_q;
  assign busy_o       = (out_cnt_q != '0);

  // outstanding count after this cycle's grant and response
  always_comb
  begin
    out_cnt_n = out_cnt_q;
    if (gnt_hs && !instr_rvalid_i)
      out_cnt_n = out_cnt_q + 1'b1;
    else if (!gnt_hs && instr_rvalid_i)
      out_cnt_n = out_cnt_q - 1'b1;
  end

  //////////////////////////////////////////////////////////////////////
  // address generation and transaction tracking
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active_q      <= 1'b0;
      fetch_addr_q  <= '0;
      rsp_pc_q      <= '0;
      out_cnt_q     <= '0;
      discard_cnt_q <= '0;
    end
    else
    begin
      out_cnt_q <= out_cnt_n;
      if (branch_req_i)
      begin
        // redirect restarts both request and response address
        active_q     <= 1'b1;
        fetch_addr_q <= {branch_addr_i[XLEN-1:2], 2'b00};
        rsp_pc_q     <= {branch_addr_i[XLEN-1:2], 2'b00};
      end
      else if (kill_i)
        // next kept response is the next unrequested word
        rsp_pc_q <= fetch_addr_q;
      else
      begin
        if (gnt_hs)
          fetch_addr_q <= fetch_addr_q + 32'd4;
        if (push)
          rsp_pc_q <= rsp_pc_q + 32'd4;
      end
      // every transaction still in flight at a flush is thrown away
      if (flush)
        discard_cnt_q <= out_cnt_n;
      else if (rsp_drop)
        discard_cnt_q <= discard_cnt_q - 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // instruction FIFO
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end
    else if (flush)
    begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fifo_cnt_q <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push && !pop)
        fifo_cnt_q <= fifo_cnt_q + 1'b1;
      else if (pop && !push)
        fifo_cnt_q <= fifo_cnt_q - 1'b1;
    end
  end

  // word, bus error and its PC
  always_ff @(posedge clk)
  begin
    if (push)
    begin
      data_q[wr_ptr_q] <= instr_rdata_i;
      err_q[wr_ptr_q]  <= instr_err_i;
      pc_q[wr_ptr_q]   <= rsp_pc_q;
    end
  end

  assign valid_o = (fifo_cnt_q != '0);
  assign instr_o = data_q[rd_ptr_q];
  assign err_o   = err_q[rd_ptr_q];
  assign pc_o    = pc_q[rd_ptr_q];

endmodule

// File: source/fetch_pc_select.sv
/*
  Next fetch address selection for a redirect.
  Purely combinational; the fetch stage feeds the result to the prefetch
  unit together with pc_set_i.
*/

`timescale 1ns/1ps

module fetch_pc_select (
  input  fetch_pkg::pc_src_e              pc_src_i,
  input  fetch_pkg::trap_vec_e            trap_vec_i,
  input  logic [fetch_pkg::IRQ_ID_W-1:0]  irq_id_i,
  input  logic [fetch_pkg::XLEN-1:0]      boot_addr_i,
  input  logic [23:0]                     mtvec_addr_i,
  input  logic [fetch_pkg::XLEN-1:0]      dm_halt_addr_i,
  input  logic [fetch_pkg::XLEN-1:0]      dm_exception_addr_i,
  input  logic [fetch_pkg::XLEN-1:0]      jump_target_i,
  input  logic [fetch_pkg::XLEN-1:0]      branch_target_i,
  input  logic [fetch_pkg::XLEN-1:0]      mepc_i,
  input  logic [fetch_pkg::XLEN-1:0]      dpc_i,
  input  logic [fetch_pkg::XLEN-1:0]      wb_pc_i,
  output logic [fetch_pkg::XLEN-1:0]      target_o
);
  import fetch_pkg::*;

  logic [XLEN-1:0] trap_addr;
  logic [XLEN-1:0] sel_addr;

  // trap target
  always_comb
  begin
    case (trap_vec_i)
      // all exceptions share the table base
      TRAP_EXC:      trap_addr = {mtvec_addr_i, 8'h00};
      // one word per interrupt line above the base
      TRAP_IRQ:      trap_addr = {mtvec_addr_i, 1'b0, irq_id_i, 2'b00};
      TRAP_DBG_HALT: trap_addr = {dm_halt_addr_i[XLEN-1:2], 2'b00};
      TRAP_DBG_EXC:  trap_addr = {dm_exception_addr_i[XLEN-1:2], 2'b00};
      default:       trap_addr = {mtvec_addr_i, 8'h00};
    endcase
  end

  // source mux
  always_comb
  begin
    case (pc_src_i)
      PC_BOOT:   sel_addr = {boot_addr_i[XLEN-1:2], 2'b00};
      PC_JUMP:   sel_addr = jump_target_i;
      PC_BRANCH: sel_addr = branch_target_i;
      PC_TRAP:   sel_addr = trap_addr;
      PC_MRET:   sel_addr = mepc_i;
      PC_DRET:   sel_addr = dpc_i;
      // restart right after the fence so the refetch sees new memory
      PC_FENCEI: sel_addr = wb_pc_i + 32'd4;
      default:   sel_addr = {boot_addr_i[XLEN-1:2], 2'b00};
    endcase
  end

  // bit 0 is never set in a fetch address
  assign target_o = {sel_addr[XLEN-1:1], 1'b0};

endmodule

// File: source/fetch_pkg.sv
/*
  Shared types and sizing for the instruction fetch subsystem.
  Imported by the RTL modules and by the testbench checker.
*/

package fetch_pkg;

  //////////////////////////////////////////////////////////////////////
  // sizing
  //////////////////////////////////////////////////////////////////////

  // address and instruction width
  localparam int XLEN = 32;

  // prefetch FIFO entries, also the limit on transactions in flight
  localparam int FETCH_FIFO_DEPTH = 2;

  // vectored interrupt index width
  localparam int IRQ_ID_W = 5;

  // addi x0, x0, 0 held in IF/ID after reset
  localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

  //////////////////////////////////////////////////////////////////////
  // enums
  //////////////////////////////////////////////////////////////////////

  // where the next fetch comes from on a redirect
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_BRANCH,
    PC_TRAP,
    PC_MRET,
    PC_DRET,
    PC_FENCEI
  } pc_src_e;

  // kind of trap target
  typedef enum logic [1:0] {
    TRAP_EXC,
    TRAP_IRQ,
    TRAP_DBG_HALT,
    TRAP_DBG_EXC
  } trap_vec_e;

  // compressed forms handled by the expander
  typedef enum logic [3:0] {
    C_ADDI,
    C_LI,
    C_LW,
    C_SW,
    C_J,
    C_MV,
    C_ADD,
    C_ILLEGAL
  } rvc_op_e;

endpackage
